// ==== priv_macros.svh ====
/* register width and status field bit positions for the RV64 privilege unit */

`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

`default_nettype none

// register width, fixed at RV64
`define XLEN 64

// mstatus fields
`define MSTATUS_MIE    3  // machine interrupt enable
`define MSTATUS_MPIE   7  // mie before trap
`define MSTATUS_MPP_LO 11 // mpp is two bits, 12:11

// sstatus fields
`define SSTATUS_SIE    1  // supervisor interrupt enable
`define SSTATUS_SPIE   5  // sie before trap
`define SSTATUS_SPP    8  // one bit, 1 means came from S

// ustatus fields
`define USTATUS_UIE    0  // user interrupt enable
`define USTATUS_UPIE   4  // uie before trap

`default_nettype wire

`endif

// ==== priv_pkg.sv ====
/* privilege mode, CSR op and CSR address enums */

`default_nettype none

package priv_pkg;

    // privilege levels, 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_mode_e;

    // kind of csr access
    typedef enum logic [1:0] {
        CSR_NONE = 2'd0, // no access
        CSR_RW   = 2'd1, // swap
        CSR_RS   = 2'd2, // set bits
        CSR_RC   = 2'd3  // clear bits
    } csr_op_e;

    // implemented csr addresses, everything else reads zero
    typedef enum logic [11:0] {
        CSR_USTATUS  = 12'h000,
        CSR_UEPC     = 12'h041,
        CSR_SSTATUS  = 12'h100,
        CSR_SEPC     = 12'h141,
        CSR_SATP     = 12'h180,
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343
    } csr_addr_e;

endpackage

`default_nettype wire

// ==== csr_req_if.sv ====
/* CSR access request from decoder to CSR file */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

interface csr_req_if;

    logic               valid; // one-cycle strobe, no stall
    priv_pkg::csr_op_e  op;    // rw / rs / rc
    logic [11:0]        addr;  // raw csr address, may be unimplemented
    logic [`XLEN-1:0]   wdata; // rs1 value or zero-extended zimm

    // decode side drives everything
    modport decoder (
        output valid,
        output op,
        output addr,
        output wdata
    );

    // csr file only listens
    modport csr_file (
        input valid,
        input op,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

// ==== csr_decode.sv ====
/* CSR instruction decode, funct3 and operand select into a CSR request */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

module csr_decode (
    input  wire logic               instr_valid, // not a bubble
    input  wire logic [2:0]         funct3,
    input  wire logic [11:0]        csr_addr,
    input  wire logic [`XLEN-1:0]   rs1_val,
    input  wire logic [4:0]         zimm,        // rs1 field as immediate
    csr_req_if.decoder              req
);

    logic             use_imm;  // funct3[2] picks the immediate form
    logic [`XLEN-1:0] zimm_ext;

    assign use_imm  = funct3[2];
    assign zimm_ext = {{(`XLEN-5){1'b0}}, zimm}; // zero-extend

    // address goes straight through so the read is always live
    assign req.addr  = csr_addr;
    assign req.wdata = use_imm ? zimm_ext : rs1_val;

    always_comb begin
        req.op    = priv_pkg::CSR_NONE;
        req.valid = 1'b0;
        case (funct3)
            3'd1, 3'd5: begin
                req.op    = priv_pkg::CSR_RW;  // csrrw / csrrwi
                req.valid = instr_valid;
            end
            3'd2, 3'd6: begin
                req.op    = priv_pkg::CSR_RS;  // csrrs / csrrsi
                req.valid = instr_valid;
            end
            3'd3, 3'd7: begin
                req.op    = priv_pkg::CSR_RC;  // csrrc / csrrci
                req.valid = instr_valid;
            end
            default: begin
                // 0 is ecall/ebreak/xret space, 4 is unused
                req.op    = priv_pkg::CSR_NONE;
                req.valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== priv_csr_file.sv ====
/* sparse CSR file with permission check, read/modify/write,
   trap entry, mret/sret/uret and current privilege mode */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

module priv_csr_file (
    input  wire logic                clk,
    input  wire logic                reset,
    csr_req_if.csr_file              req,
    input  wire logic                trap_en,
    input  wire logic [`XLEN-1:0]    trap_cause,   // bit 63 set for interrupt
    input  wire logic [`XLEN-1:0]    trap_pc,
    input  wire logic [`XLEN-1:0]    trap_val,
    input  wire logic                mret,
    input  wire logic                sret,
    input  wire logic                uret,
    output logic [`XLEN-1:0]         csr_rdata,    // old value, same cycle
    output logic                     csr_fault,
    output logic                     satp_write,   // tells the mmu to flush
    output logic [`XLEN-1:0]         handler_addr,
    output logic [`XLEN-1:0]         mepc,
    output logic [`XLEN-1:0]         sepc,
    output logic [`XLEN-1:0]         uepc,
    output logic [`XLEN-1:0]         satp,
    output priv_pkg::priv_mode_e     priv_mode
);

    logic [`XLEN-1:0] ustatus;
    logic [`XLEN-1:0] sstatus;
    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mtval;

    logic             is_write;
    logic             ro_violation;   // write to read-only space
    logic             priv_violation; // mode too low for this csr
    logic             wr_en;
    logic [`XLEN-1:0] wr_data;
    logic [`XLEN-1:0] mtvec_base;

    // combinational read, unimplemented addresses give zero
    always_comb begin
        case (req.addr)
            priv_pkg::CSR_USTATUS:  csr_rdata = ustatus;
            priv_pkg::CSR_UEPC:     csr_rdata = uepc;
            priv_pkg::CSR_SSTATUS:  csr_rdata = sstatus;
            priv_pkg::CSR_SEPC:     csr_rdata = sepc;
            priv_pkg::CSR_SATP:     csr_rdata = satp;
            priv_pkg::CSR_MSTATUS:  csr_rdata = mstatus;
            priv_pkg::CSR_MTVEC:    csr_rdata = mtvec;
            priv_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            priv_pkg::CSR_MEPC:     csr_rdata = mepc;
            priv_pkg::CSR_MCAUSE:   csr_rdata = mcause;
            priv_pkg::CSR_MTVAL:    csr_rdata = mtval;
            default:                csr_rdata = '0;
        endcase
    end

    // permission bits come from the address itself
    assign is_write       = req.valid && (req.op != priv_pkg::CSR_NONE);
    assign ro_violation   = is_write && (req.addr[11:10] == 2'b11);
    assign priv_violation = req.valid && (priv_mode < req.addr[9:8]);
    assign csr_fault      = ro_violation || priv_violation;

    assign wr_en      = is_write && !csr_fault; // denied access is dropped
    assign satp_write = wr_en && (req.addr == priv_pkg::CSR_SATP);

    always_comb begin
        case (req.op)
            priv_pkg::CSR_RW: wr_data = req.wdata;
            priv_pkg::CSR_RS: wr_data = csr_rdata | req.wdata;
            priv_pkg::CSR_RC: wr_data = csr_rdata & ~req.wdata;
            default:          wr_data = csr_rdata;
        endcase
    end

    // trap vector, modes 2 and 3 fall back to direct
    assign mtvec_base = {mtvec[`XLEN-1:2], 2'b00};
    always_comb begin
        if (mtvec[1:0] == 2'b01 && trap_cause[`XLEN-1]) begin
            handler_addr = mtvec_base + {trap_cause[`XLEN-3:0], 2'b00}; // base + 4*cause
        end else begin
            handler_addr = mtvec_base;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ustatus   <= '0;
            uepc      <= '0;
            sstatus   <= '0;
            sepc      <= '0;
            satp      <= '0;
            mstatus   <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            priv_mode <= priv_pkg::PRIV_M; // boot in machine mode
        end else begin
            // csr instruction write first, trap/xret below override per field
            if (wr_en) begin
                case (req.addr)
                    priv_pkg::CSR_USTATUS:  ustatus  <= wr_data;
                    priv_pkg::CSR_UEPC:     uepc     <= wr_data;
                    priv_pkg::CSR_SSTATUS:  sstatus  <= wr_data;
                    priv_pkg::CSR_SEPC:     sepc     <= wr_data;
                    priv_pkg::CSR_SATP:     satp     <= wr_data;
                    priv_pkg::CSR_MSTATUS:  mstatus  <= wr_data;
                    priv_pkg::CSR_MTVEC:    mtvec    <= wr_data;
                    priv_pkg::CSR_MSCRATCH: mscratch <= wr_data;
                    priv_pkg::CSR_MEPC:     mepc     <= wr_data;
                    priv_pkg::CSR_MCAUSE:   mcause   <= wr_data;
                    priv_pkg::CSR_MTVAL:    mtval    <= wr_data;
                    default: ;                         // unimplemented, ignored
                endcase
            end

            if (trap_en) begin
                // no delegation, every trap lands in M
                mepc   <= trap_pc;
                mcause <= trap_cause;
                mtval  <= trap_val;
                mstatus[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] <= priv_mode; // remember old mode
                mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
                mstatus[`MSTATUS_MIE]  <= 1'b0;
                priv_mode <= priv_pkg::PRIV_M;
            end else if (mret) begin
                priv_mode <= priv_pkg::priv_mode_e'(mstatus[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO]);
                mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
                mstatus[`MSTATUS_MPIE] <= 1'b1;
                mstatus[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] <= priv_pkg::PRIV_U;
            end else if (sret) begin
                priv_mode <= sstatus[`SSTATUS_SPP] ? priv_pkg::PRIV_S : priv_pkg::PRIV_U;
                sstatus[`SSTATUS_SIE]  <= sstatus[`SSTATUS_SPIE];
                sstatus[`SSTATUS_SPIE] <= 1'b1;
                sstatus[`SSTATUS_SPP]  <= 1'b0;
            end else if (uret) begin
                priv_mode <= priv_pkg::PRIV_U;
                ustatus[`USTATUS_UIE]  <= ustatus[`USTATUS_UPIE];
                ustatus[`USTATUS_UPIE] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pc_redirect.sv ====
/* registered fetch redirect on trap or xret */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

module pc_redirect (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               trap_en,
    input  wire logic               mret,
    input  wire logic               sret,
    input  wire logic               uret,
    input  wire logic [`XLEN-1:0]   handler_addr, // from mtvec, this cycle
    input  wire logic [`XLEN-1:0]   mepc,
    input  wire logic [`XLEN-1:0]   sepc,
    input  wire logic [`XLEN-1:0]   uepc,
    output logic                    redirect_valid,
    output logic [`XLEN-1:0]        redirect_pc
);

    logic             redirect_event;
    logic [`XLEN-1:0] next_pc;

    assign redirect_event = trap_en || mret || sret || uret;

    // same priority as the csr file, trap wins
    always_comb begin
        if (trap_en) begin
            next_pc = handler_addr;
        end else if (mret) begin
            next_pc = mepc;
        end else if (sret) begin
            next_pc = sepc;
        end else begin
            next_pc = uepc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= redirect_event; // one-cycle pulse per event
        end
    end

    // target only loads on an event, held otherwise
    always_ff @(posedge clk) begin
        if (redirect_event) begin
            redirect_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== priv_unit_top.sv ====
/* privilege unit top, decoder, CSR file and redirect stage */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

module priv_unit_top (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               instr_valid,
    input  wire logic [2:0]         funct3,
    input  wire logic [11:0]        csr_addr,
    input  wire logic [`XLEN-1:0]   rs1_val,
    input  wire logic [4:0]         zimm,
    input  wire logic               trap_en,
    input  wire logic [`XLEN-1:0]   trap_cause,
    input  wire logic [`XLEN-1:0]   trap_pc,
    input  wire logic [`XLEN-1:0]   trap_val,
    input  wire logic               mret,
    input  wire logic               sret,
    input  wire logic               uret,
    output logic [`XLEN-1:0]        csr_rdata,      // value for rd
    output logic                    csr_fault,
    output logic                    satp_write,
    output logic [`XLEN-1:0]        satp,
    output priv_pkg::priv_mode_e    priv_mode,
    output logic                    redirect_valid,
    output logic [`XLEN-1:0]        redirect_pc
);

    logic [`XLEN-1:0] handler_addr; // trap target, combinational
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] sepc;
    logic [`XLEN-1:0] uepc;

    csr_req_if csr_req ();

    csr_decode u_decode (
        .instr_valid (instr_valid),
        .funct3      (funct3),
        .csr_addr    (csr_addr),
        .rs1_val     (rs1_val),
        .zimm        (zimm),
        .req         (csr_req.decoder)
    );

    priv_csr_file u_csr_file (
        .clk          (clk),
        .reset        (reset),
        .req          (csr_req.csr_file),
        .trap_en      (trap_en),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .trap_val     (trap_val),
        .mret         (mret),
        .sret         (sret),
        .uret         (uret),
        .csr_rdata    (csr_rdata),
        .csr_fault    (csr_fault),
        .satp_write   (satp_write),
        .handler_addr (handler_addr),
        .mepc         (mepc),
        .sepc         (sepc),
        .uepc         (uepc),
        .satp         (satp),
        .priv_mode    (priv_mode)
    );

    // same strobes fan out here so state and redirect move on one edge
    pc_redirect u_redirect (
        .clk            (clk),
        .reset          (reset),
        .trap_en        (trap_en),
        .mret           (mret),
        .sret           (sret),
        .uret           (uret),
        .handler_addr   (handler_addr),
        .mepc           (mepc),
        .sepc           (sepc),
        .uepc           (uepc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== priv_unit_checker.sv ====
/* bound assertions on redirect pulse, reset state and satp flag */

`timescale 1ns/1ps
`default_nettype none

module priv_unit_checker (
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       redirect_event, // any trap or xret strobe
    input wire logic       redirect_valid,
    input wire logic [1:0] priv_mode,
    input wire logic       csr_fault,
    input wire logic       satp_write
);

    // every pulse traces back to an event one cycle earlier
    a_pulse_source: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> $past(redirect_event))
        else $error("redirect_valid without a trap or return on the cycle before");

    a_no_stretch: assert property (@(posedge clk) disable iff (reset)
        (redirect_valid && $past(redirect_valid)) |-> $past(redirect_event))
        else $error("redirect_valid held two cycles without a new event");

    // first cycle out of reset
    a_reset_state: assert property (@(posedge clk)
        ($past(reset) && !reset) |-> (priv_mode == 2'd3 && !redirect_valid))
        else $error("mode not M or redirect active right after reset");

    a_fault_no_satp: assert property (@(posedge clk) disable iff (reset)
        csr_fault |-> !satp_write)
        else $error("satp_write raised on a faulting access");

endmodule

bind priv_unit_top priv_unit_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .redirect_event (trap_en || mret || sret || uret),
    .redirect_valid (redirect_valid),
    .priv_mode      (priv_mode),
    .csr_fault      (csr_fault),
    .satp_write     (satp_write)
);

`default_nettype wire

// ==== priv_unit_tb.sv ====
/* testbench for the privilege unit, seeded random CSR traffic, traps and
   returns checked against a CSR model, watchdog and summary */

`timescale 1ns/1ps
`include "priv_macros.svh"
`default_nettype none

module priv_unit_tb;

    localparam int RAND_OPS = 300;
    localparam int TRAPS    = 9;
    localparam int RETURNS  = 6;
    localparam int LOW_OPS  = 20; // random ops after each return
    localparam int NUM_OPS  = RAND_OPS + TRAPS * 4 + RETURNS * (LOW_OPS + 16);

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 instr_valid;
    logic [2:0]           funct3;
    logic [11:0]          csr_addr;
    logic [`XLEN-1:0]     rs1_val;
    logic [4:0]           zimm;
    logic                 trap_en;
    logic [`XLEN-1:0]     trap_cause;
    logic [`XLEN-1:0]     trap_pc;
    logic [`XLEN-1:0]     trap_val;
    logic                 mret;
    logic                 sret;
    logic                 uret;
    logic [`XLEN-1:0]     csr_rdata;
    logic                 csr_fault;
    logic                 satp_write;
    logic [`XLEN-1:0]     satp;
    priv_pkg::priv_mode_e priv_mode;
    logic                 redirect_valid;
    logic [`XLEN-1:0]     redirect_pc;

    logic [`XLEN-1:0] model [logic [11:0]]; // implemented csrs only
    logic [1:0]       model_mode;
    int               n_checks;
    int               n_errors;
    logic [11:0]      impl_addrs [11] = '{12'h000, 12'h041, 12'h100, 12'h141, 12'h180,
                                          12'h300, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343};

    priv_unit_top UUT (.*);

    always #2 clk = ~clk; // 4 ns period

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [63:0] model_read(logic [11:0] addr);
        return model.exists(addr) ? model[addr] : 64'd0; // unimplemented reads zero
    endfunction

    task automatic read_check(logic [11:0] addr);
        @(posedge clk) #1;
        csr_addr = addr;
        #1;
        check_eq($sformatf("readback %h", addr), model_read(addr), csr_rdata);
    endtask

    // one csr instruction, old value and flags mid-cycle, new value next cycle
    task automatic csr_op(logic [2:0] f3, logic [11:0] addr, logic [63:0] rs1);
        logic [63:0] wdata;
        logic [63:0] old;
        logic        fault;
        @(posedge clk) #1;
        instr_valid = 1'b1;
        funct3      = f3;
        csr_addr    = addr;
        rs1_val     = rs1;
        zimm        = 5'($urandom);
        wdata = f3[2] ? {59'd0, zimm} : rs1; // immediate forms zero-extend
        old   = model_read(addr);
        fault = (f3[1:0] != 2'd0) && (addr[11:10] == 2'b11 || model_mode < addr[9:8]);
        #1;
        check_eq($sformatf("old value %h", addr), old, csr_rdata);
        check_eq($sformatf("fault %h", addr), fault, csr_fault);
        check_eq("satp_write", f3[1:0] != 2'd0 && !fault && addr == 12'h180, satp_write);
        if (!fault && model.exists(addr)) begin
            case (f3[1:0])
                2'd1:    model[addr] = wdata;
                2'd2:    model[addr] = old | wdata;
                2'd3:    model[addr] = old & ~wdata;
                default: ;
            endcase
        end
        @(posedge clk) #1;
        instr_valid = 1'b0;
        #1;
        check_eq($sformatf("new value %h", addr), model_read(addr), csr_rdata);
        check_eq("satp output", model_read(12'h180), satp);
    endtask

    task automatic random_op();
        logic [11:0] addr;
        addr = ($urandom % 8 == 0) ? 12'($urandom) : impl_addrs[$urandom % 11];
        csr_op(3'($urandom), addr, {$urandom, $urandom});
    endtask

    // called one ns after the edge that took the event
    task automatic expect_redirect(string name, logic [63:0] target);
        check_eq({name, " valid"}, 1'b1, redirect_valid);
        check_eq({name, " pc"}, target, redirect_pc);
        check_eq({name, " mode"}, model_mode, priv_mode);
        @(posedge clk) #1;
        check_eq({name, " pulse end"}, 1'b0, redirect_valid);
    endtask

    task automatic take_trap(logic irq);
        logic [63:0] cause;
        logic [63:0] tvec;
        logic [63:0] handler;
        logic [63:0] st;
        cause     = {$urandom, $urandom} & 64'h0000_0000_0000_00ff; // cause code
        cause[63] = irq;                                          // interrupt bit
        tvec    = model_read(12'h305);
        handler = tvec & ~64'd3;
        if (tvec[1:0] == 2'd1 && cause[63])
            handler = handler + 4 * (cause & ~(64'd1 << 63));
        @(posedge clk) #1;
        trap_en    = 1'b1;
        trap_cause = cause;
        trap_pc    = {$urandom, $urandom};
        trap_val   = {$urandom, $urandom};
        model[12'h341] = trap_pc;
        model[12'h342] = cause;
        model[12'h343] = trap_val;
        st = model[12'h300];
        st[`MSTATUS_MPP_LO +: 2] = model_mode;
        st[`MSTATUS_MPIE]        = st[`MSTATUS_MIE];
        st[`MSTATUS_MIE]         = 1'b0;
        model[12'h300] = st;
        model_mode     = 2'd3;
        @(posedge clk) #1;
        trap_en = 1'b0;
        expect_redirect("trap", handler);
        read_check(12'h341);
        read_check(12'h342);
        read_check(12'h343);
        read_check(12'h300);
    endtask

    task automatic do_return(int kind);
        logic [63:0] st;
        logic [63:0] target;
        logic [11:0] st_addr;
        @(posedge clk) #1;
        case (kind)
            0: begin
                mret    = 1'b1;
                st_addr = 12'h300;
                st      = model[st_addr];
                target  = model[12'h341];
                model_mode               = st[`MSTATUS_MPP_LO +: 2];
                st[`MSTATUS_MIE]         = st[`MSTATUS_MPIE];
                st[`MSTATUS_MPIE]        = 1'b1;
                st[`MSTATUS_MPP_LO +: 2] = 2'd0;
            end
            1: begin
                sret    = 1'b1;
                st_addr = 12'h100;
                st      = model[st_addr];
                target  = model[12'h141];
                model_mode        = st[`SSTATUS_SPP] ? 2'd1 : 2'd0;
                st[`SSTATUS_SIE]  = st[`SSTATUS_SPIE];
                st[`SSTATUS_SPIE] = 1'b1;
                st[`SSTATUS_SPP]  = 1'b0;
            end
            default: begin
                uret    = 1'b1;
                st_addr = 12'h000;
                st      = model[st_addr];
                target  = model[12'h041];
                model_mode        = 2'd0;
                st[`USTATUS_UIE]  = st[`USTATUS_UPIE];
                st[`USTATUS_UPIE] = 1'b1;
            end
        endcase
        model[st_addr] = st;
        @(posedge clk) #1;
        mret = 1'b0;
        sret = 1'b0;
        uret = 1'b0;
        expect_redirect("return", target);
        read_check(st_addr);
    endtask

    initial begin
        #(NUM_OPS * 4 * 4);
        $display("timeout: run still busy after %0d ns", NUM_OPS * 16);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h7446_98c7));
        n_checks    = 0;
        n_errors    = 0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        funct3      = 3'd0;
        csr_addr    = 12'd0;
        rs1_val     = '0;
        zimm        = 5'd0;
        trap_en     = 1'b0;
        trap_cause  = '0;
        trap_pc     = '0;
        trap_val    = '0;
        mret        = 1'b0;
        sret        = 1'b0;
        uret        = 1'b0;
        foreach (impl_addrs[i]) model[impl_addrs[i]] = '0;
        model_mode = 2'd3;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        repeat (RAND_OPS) random_op(); // all in M mode

        for (int t = 0; t < TRAPS; t++) begin
            logic [63:0] tv;
            tv      = {$urandom, $urandom};
            tv[1:0] = 2'(t % 3); // direct, vectored, reserved
            csr_op(3'd1, 12'h305, tv);
            take_trap(1'((t / 3) % 2)); // each tvec mode sees exceptions and interrupts
        end

        for (int r = 0; r < RETURNS; r++) begin
            logic [63:0] st;
            st = {$urandom, $urandom};
            case (r % 3)
                0: begin
                    st[`MSTATUS_MPP_LO +: 2] = (r < 3) ? 2'd1 : 2'd0; // S first, then U
                    csr_op(3'd1, 12'h300, st);
                    csr_op(3'd1, 12'h341, {$urandom, $urandom});
                end
                1: begin
                    csr_op(3'd1, 12'h100, st); // random spp
                    csr_op(3'd1, 12'h141, {$urandom, $urandom});
                end
                default: begin
                    csr_op(3'd1, 12'h000, st);
                    csr_op(3'd1, 12'h041, {$urandom, $urandom});
                end
            endcase
            do_return(r % 3);
            repeat (LOW_OPS) random_op();
            csr_op(3'd1, {2'b11, 10'($urandom)}, {$urandom, $urandom}); // read-only space
            take_trap(1'($urandom));
        end

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
priv_pkg.sv
csr_req_if.sv
csr_decode.sv
priv_csr_file.sv
pc_redirect.sv
priv_unit_top.sv
priv_unit_checker.sv
priv_unit_tb.sv
